/* logic/dhcp_pkg.sv */
`default_nettype none

package dhcp_pkg;

  typedef logic [31:0] ipv4_t;
  typedef logic [47:0] mac_addr_t;

  // values of the DHCP message-type option (option 53).
  typedef enum logic [7:0] {
    dhcp_discover = 8'd1,
    dhcp_offer    = 8'd2,
    dhcp_request  = 8'd3,
    dhcp_ack      = 8'd5,
    dhcp_nak      = 8'd6
  } dhcp_msg_type_e;

  typedef enum logic [2:0] {
    idle_s,
    discover_s,
    wait_offer_s,
    request_s,
    wait_ack_s,
    bound_s
  } client_state_e;

  // fixed header fields; hops, secs, giaddr, sname and file are zero on the wire.
  typedef struct packed {
    logic [7:0]  op;
    logic [7:0]  htype;
    logic [7:0]  hlen;
    logic [31:0] xid;
    logic [15:0] flags;
    ipv4_t       ciaddr;
    ipv4_t       yiaddr;
    ipv4_t       siaddr;
    mac_addr_t   chaddr;
    logic [31:0] cookie;
  } dhcp_hdr_t;

  typedef struct packed {
    dhcp_msg_type_e msg_type;
    ipv4_t          req_ip;
    logic           req_ip_pres;
    ipv4_t          server_id;
    logic           server_id_pres;
  } dhcp_opt_t;

  typedef struct packed {
    logic      val;
    dhcp_hdr_t hdr;
    dhcp_opt_t opt;
    ipv4_t     src_ip;
    ipv4_t     dst_ip;
  } dhcp_msg_t;

  typedef struct packed {
    logic           val;
    dhcp_msg_type_e kind;
    ipv4_t          req_ip;
    ipv4_t          server_ip;
    logic           secs;
  } send_cmd_t;

  typedef struct packed {
    logic           val;
    dhcp_msg_type_e kind;
    ipv4_t          yiaddr;
    ipv4_t          server_id;
  } lease_t;

  localparam logic [31:0] DHCP_COOKIE = 32'h63825363;
  localparam logic [7:0]  BOOTREQUEST = 8'd1;
  localparam logic [7:0]  BOOTREPLY   = 8'd2;

endpackage : dhcp_pkg

`default_nettype wire

/* logic/dhcp_rx_filter.sv */
`default_nettype none

module dhcp_rx_filter
  import dhcp_pkg::*;
#(
  parameter mac_addr_t   MAC_ADDR = 48'h02_00_00_00_00_01,
  parameter logic [31:0] XID      = 32'hdeadface
) (
  input  logic      clk,
  input  logic      fsm_rst,
  input  dhcp_msg_t rx,
  output lease_t    lease
);

  logic  accept;
  logic  type_ok;
  ipv4_t srv_id;

  // only server replies to our transaction and our hardware address pass.
  assign type_ok = rx.opt.msg_type inside {dhcp_offer, dhcp_ack, dhcp_nak};

  assign accept = rx.val &&
                  (rx.hdr.op == BOOTREPLY) &&
                  (rx.hdr.xid == XID) &&
                  (rx.hdr.chaddr == MAC_ADDR) &&
                  (rx.hdr.cookie == DHCP_COOKIE) &&
                  type_ok;

  // a server that leaves out option 54 is identified by siaddr.
  assign srv_id = rx.opt.server_id_pres ? rx.opt.server_id : rx.hdr.siaddr;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      lease.val <= 1'b0;
    end else begin
      lease.val <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      lease.kind      <= rx.opt.msg_type;
      lease.yiaddr    <= rx.hdr.yiaddr;
      lease.server_id <= srv_id;
    end
  end

endmodule : dhcp_rx_filter

`default_nettype wire

/* logic/dhcp_client_fsm.sv */
`default_nettype none

module dhcp_client_fsm
  import dhcp_pkg::*;
#(
  parameter logic [31:0] TIMEOUT_TICKS = 32'd1000,
  parameter logic [3:0]  RETRIES       = 4'd3
) (
  input  logic      clk,
  input  logic      fsm_rst,
  input  logic      ipv4_req,
  input  ipv4_t     ipv4_addr,
  input  lease_t    lease,
  output send_cmd_t cmd,
  output logic      ipv4_addr_val,
  output ipv4_t     bound_ip,
  output logic      ok,
  output logic      timeout
);

  client_state_e state;
  logic [31:0]   tmr;
  logic [3:0]    retry_cnt;
  logic          tmr_expired;
  ipv4_t         offered_ip;
  ipv4_t         server_ip;

  // the send states last one cycle, so the timer starts at one there and
  // successive discovers are TIMEOUT_TICKS apart.
  assign tmr_expired = (tmr >= TIMEOUT_TICKS - 32'd1);

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state         <= idle_s;
      tmr           <= '0;
      retry_cnt     <= '0;
      ipv4_addr_val <= 1'b0;
      ok            <= 1'b0;
      timeout       <= 1'b0;
    end else begin
      timeout <= 1'b0;
      case (state)
        idle_s: begin
          if (ipv4_req) begin
            retry_cnt <= '0;
            state     <= discover_s;
          end
        end
        discover_s: begin
          tmr   <= 32'd1;
          state <= wait_offer_s;
        end
        wait_offer_s: begin
          tmr <= tmr + 32'd1;
          // acks and naks are not expected before an offer.
          if (lease.val && lease.kind == dhcp_offer) begin
            state <= request_s;
          end else if (tmr_expired) begin
            if (retry_cnt == RETRIES) begin
              timeout <= 1'b1;
              state   <= idle_s;
            end else begin
              retry_cnt <= retry_cnt + 4'd1;
              state     <= discover_s;
            end
          end
        end
        request_s: begin
          tmr   <= 32'd1;
          state <= wait_ack_s;
        end
        wait_ack_s: begin
          tmr <= tmr + 32'd1;
          if (lease.val && lease.kind == dhcp_ack) begin
            ipv4_addr_val <= 1'b1;
            ok            <= 1'b1;
            state         <= bound_s;
          end else if (lease.val && lease.kind == dhcp_nak) begin
            state <= discover_s;
          end else if (tmr_expired) begin
            if (retry_cnt == RETRIES) begin
              timeout <= 1'b1;
              state   <= idle_s;
            end else begin
              retry_cnt <= retry_cnt + 4'd1;
              state     <= discover_s;
            end
          end
        end
        bound_s: begin
          // a new request drops the lease and starts over.
          if (ipv4_req) begin
            ipv4_addr_val <= 1'b0;
            ok            <= 1'b0;
            retry_cnt     <= '0;
            state         <= discover_s;
          end
        end
        default: state <= idle_s;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == wait_offer_s && lease.val && lease.kind == dhcp_offer) begin
      offered_ip <= lease.yiaddr;
      server_ip  <= lease.server_id;
    end
    if (state == wait_ack_s && lease.val && lease.kind == dhcp_ack) begin
      bound_ip <= lease.yiaddr;
    end
  end

  // send commands are decoded from the one-cycle send states.
  always_comb begin
    cmd = '0;
    case (state)
      discover_s: begin
        cmd.val    = 1'b1;
        cmd.kind   = dhcp_discover;
        cmd.req_ip = ipv4_addr;
      end
      request_s: begin
        cmd.val       = 1'b1;
        cmd.kind      = dhcp_request;
        cmd.req_ip    = offered_ip;
        cmd.server_ip = server_ip;
      end
      default: cmd = '0;
    endcase
  end

endmodule : dhcp_client_fsm

`default_nettype wire

/* logic/dhcp_tx_builder.sv */
`default_nettype none

module dhcp_tx_builder
  import dhcp_pkg::*;
#(
  parameter mac_addr_t   MAC_ADDR = 48'h02_00_00_00_00_01,
  parameter logic [31:0] XID      = 32'hdeadface
) (
  input  logic      clk,
  input  logic      fsm_rst,
  input  send_cmd_t cmd,
  output dhcp_msg_t tx
);

  logic is_request;

  assign is_request = (cmd.kind == dhcp_request);

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      tx.val <= 1'b0;
    end else begin
      tx.val <= cmd.val;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd.val) begin
      tx.hdr.op     <= BOOTREQUEST;
      tx.hdr.htype  <= 8'd1;
      tx.hdr.hlen   <= 8'd6;
      tx.hdr.xid    <= XID;
      // ask the server to broadcast its reply because we have no address yet.
      tx.hdr.flags  <= 16'h8000;
      tx.hdr.ciaddr <= '0;
      tx.hdr.yiaddr <= '0;
      tx.hdr.siaddr <= '0;
      tx.hdr.chaddr <= MAC_ADDR;
      tx.hdr.cookie <= DHCP_COOKIE;

      tx.opt.msg_type       <= cmd.kind;
      tx.opt.req_ip         <= cmd.req_ip;
      tx.opt.req_ip_pres    <= (cmd.req_ip != '0);
      tx.opt.server_id      <= is_request ? cmd.server_ip : '0;
      tx.opt.server_id_pres <= is_request;

      tx.src_ip <= 32'h0000_0000;
      tx.dst_ip <= 32'hffff_ffff;
    end
  end

endmodule : dhcp_tx_builder

`default_nettype wire

/* logic/dhcp_client.sv */
`default_nettype none

module dhcp_client
  import dhcp_pkg::*;
#(
  parameter mac_addr_t   MAC_ADDR      = 48'h02_00_00_00_00_01,
  parameter logic [31:0] XID           = 32'hdeadface,
  parameter logic [31:0] TIMEOUT_TICKS = 32'd1000,
  parameter logic [3:0]  RETRIES       = 4'd3
) (
  input  logic      clk,
  input  logic      fsm_rst,
  input  logic      ipv4_req,
  input  ipv4_t     ipv4_addr,
  input  dhcp_msg_t rx,
  output dhcp_msg_t tx,
  output logic      ipv4_addr_val,
  output ipv4_t     bound_ip,
  output logic      ok,
  output logic      timeout
);

  lease_t    lease;
  send_cmd_t cmd;

  dhcp_rx_filter #(
    .MAC_ADDR (MAC_ADDR),
    .XID      (XID)
  ) rx_filter_i (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .rx      (rx),
    .lease   (lease)
  );

  dhcp_client_fsm #(
    .TIMEOUT_TICKS (TIMEOUT_TICKS),
    .RETRIES       (RETRIES)
  ) client_fsm_i (
    .clk           (clk),
    .fsm_rst       (fsm_rst),
    .ipv4_req      (ipv4_req),
    .ipv4_addr     (ipv4_addr),
    .lease         (lease),
    .cmd           (cmd),
    .ipv4_addr_val (ipv4_addr_val),
    .bound_ip      (bound_ip),
    .ok            (ok),
    .timeout       (timeout)
  );

  dhcp_tx_builder #(
    .MAC_ADDR (MAC_ADDR),
    .XID      (XID)
  ) tx_builder_i (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .cmd     (cmd),
    .tx      (tx)
  );

endmodule : dhcp_client

`default_nettype wire

/* verif/dhcp_client_checker.sv */
`default_nettype none

module dhcp_client_checker
  import dhcp_pkg::*;
#(
  parameter mac_addr_t   MAC_ADDR = 48'h0,
  parameter logic [31:0] XID      = 32'h0
) (
  input logic      clk,
  input dhcp_msg_t tx,
  input logic      ok,
  input logic      ipv4_addr_val,
  input ipv4_t     bound_ip,
  input logic      timeout
);

  int test_errs = 0;
  int pass_cnt  = 0;
  int fail_cnt  = 0;

  task automatic report_error(input string msg);
    $display("%s", msg);
    test_errs++;
  endtask

  task automatic compare(input string name, input string field,
                         input logic [47:0] exp, input logic [47:0] act);
    if (exp !== act) begin
      report_error($sformatf("mismatch %s %s: expected %h, actual %h", name, field, exp, act));
    end
  endtask

  // tx must fire on the last of the given clock edges and not before.
  task automatic expect_tx(input string name, input int edges, input dhcp_msg_type_e kind,
                           input ipv4_t req_ip, input ipv4_t server_id);
    int   i;
    logic is_req;
    is_req = (kind == dhcp_request);
    for (i = 1; i <= edges; i++) begin
      @(posedge clk);
      if (tx.val && i < edges) begin
        report_error($sformatf("%s: tx strobe arrived %0d cycles early", name, edges - i));
      end
    end
    if (!tx.val) begin
      report_error($sformatf("%s: the expected tx strobe did not arrive", name));
    end else begin
      compare(name, "op", BOOTREQUEST, tx.hdr.op);
      compare(name, "htype", 8'd1, tx.hdr.htype);
      compare(name, "hlen", 8'd6, tx.hdr.hlen);
      compare(name, "xid", XID, tx.hdr.xid);
      compare(name, "chaddr", MAC_ADDR, tx.hdr.chaddr);
      compare(name, "flags", 16'h8000, tx.hdr.flags);
      compare(name, "cookie", DHCP_COOKIE, tx.hdr.cookie);
      compare(name, "src_ip", 32'h0000_0000, tx.src_ip);
      compare(name, "dst_ip", 32'hffff_ffff, tx.dst_ip);
      compare(name, "msg_type", kind, tx.opt.msg_type);
      compare(name, "req_ip_pres", req_ip != 32'd0, tx.opt.req_ip_pres);
      if (req_ip != 32'd0) begin
        compare(name, "req_ip", req_ip, tx.opt.req_ip);
      end
      compare(name, "server_id_pres", is_req, tx.opt.server_id_pres);
      if (is_req) begin
        compare(name, "server_id", server_id, tx.opt.server_id);
      end
    end
  endtask

  task automatic expect_bound(input string name, input int edges, input ipv4_t ip);
    int i;
    for (i = 1; i <= edges; i++) begin
      @(posedge clk);
      if (ok && i < edges) begin
        report_error($sformatf("%s: ok rose %0d cycles early", name, edges - i));
      end
    end
    if (!ok || !ipv4_addr_val) begin
      report_error($sformatf("%s: ok and ipv4_addr_val did not both rise after the ack", name));
    end else begin
      compare(name, "bound_ip", ip, bound_ip);
    end
  endtask

  // after the last retry no discover may follow, only a single timeout pulse.
  task automatic expect_timeout(input string name, input int edges);
    int   i;
    logic seen;
    seen = 1'b0;
    for (i = 1; i <= edges && !seen; i++) begin
      @(posedge clk);
      if (tx.val) begin
        report_error($sformatf("%s: tx strobe after the last retry", name));
      end
      seen = timeout;
    end
    if (!seen) begin
      report_error($sformatf("%s: timeout did not pulse after the last retry", name));
    end else begin
      @(posedge clk);
      if (timeout) begin
        report_error($sformatf("%s: timeout stayed high for more than one cycle", name));
      end
      if (ok) begin
        report_error($sformatf("%s: ok is high after a timeout", name));
      end
    end
  endtask

  task automatic close_test(input string name);
    if (test_errs == 0) begin
      $display("test %s: pass", name);
      pass_cnt++;
    end else begin
      $display("test %s: FAIL with %0d errors", name, test_errs);
      fail_cnt++;
    end
    test_errs = 0;
  endtask

endmodule : dhcp_client_checker

`default_nettype wire

/* verif/dhcp_client_tb.sv */
`default_nettype none

module dhcp_client_tb
  import dhcp_pkg::*;
();

  localparam int          PERIOD        = 40;
  localparam mac_addr_t   MAC_ADDR      = 48'h00_1b_21_3a_4c_5d;
  localparam logic [31:0] XID           = 32'h3903_f326;
  localparam int          TIMEOUT_TICKS = 20;
  localparam int          RETRIES       = 2;

  // one test record; the field order matches the columns of the input file.
  typedef struct packed {
    ipv4_t       addr;
    logic [7:0]  op;
    logic [31:0] xid;
    mac_addr_t   chaddr;
    logic [31:0] cookie;
    logic [7:0]  mtype;
    ipv4_t       yiaddr;
    logic        sid_pres;
    ipv4_t       sid;
    ipv4_t       siaddr;
    logic [1:0]  outcome;
  } test_rec_t;

  logic      clk;
  logic      fsm_rst;
  logic      ipv4_req;
  ipv4_t     ipv4_addr;
  dhcp_msg_t rx;
  dhcp_msg_t tx;
  logic      ipv4_addr_val;
  ipv4_t     bound_ip;
  logic      ok;
  logic      timeout;

  test_rec_t          recs[$];
  string              names[$];
  string              nm;
  logic [8*200-1:0]   line_buf;
  logic [47:0]        fld [0:10];
  int                 bad_lines;
  logic               loaded;

  dhcp_client #(
    .MAC_ADDR      (MAC_ADDR),
    .XID           (XID),
    .TIMEOUT_TICKS (TIMEOUT_TICKS),
    .RETRIES       (RETRIES)
  ) dut_i (
    .clk           (clk),
    .fsm_rst       (fsm_rst),
    .ipv4_req      (ipv4_req),
    .ipv4_addr     (ipv4_addr),
    .rx            (rx),
    .tx            (tx),
    .ipv4_addr_val (ipv4_addr_val),
    .bound_ip      (bound_ip),
    .ok            (ok),
    .timeout       (timeout)
  );

  dhcp_client_checker #(
    .MAC_ADDR (MAC_ADDR),
    .XID      (XID)
  ) check_i (
    .clk           (clk),
    .tx            (tx),
    .ok            (ok),
    .ipv4_addr_val (ipv4_addr_val),
    .bound_ip      (bound_ip),
    .timeout       (timeout)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    wait (loaded);
    #((recs.size() * ((RETRIES + 1) * TIMEOUT_TICKS + 20) + 100) * PERIOD);
    $display("watchdog expired before all tests finished");
    $display("Testbench failed");
    $finish;
  end

  task automatic read_records();
    int fd;
    int cnt;
    fd = $fopen("verif/dhcp_client_input.txt", "r");
    if (fd == 0) begin
      $display("cannot open verif/dhcp_client_input.txt");
      bad_lines++;
      return;
    end
    while ($fgets(line_buf, fd) != 0) begin
      nm = "";
      cnt = $sscanf(line_buf, "%s %h %h %h %h %h %h %h %h %h %h %h", nm, fld[0], fld[1],
                    fld[2], fld[3], fld[4], fld[5], fld[6], fld[7], fld[8], fld[9], fld[10]);
      if (cnt == 12) begin
        names.push_back(nm);
        recs.push_back({fld[0][31:0], fld[1][7:0], fld[2][31:0], fld[3], fld[4][31:0],
                        fld[5][7:0], fld[6][31:0], fld[7][0], fld[8][31:0], fld[9][31:0],
                        fld[10][1:0]});
      end else if (cnt > 0 && nm != "#") begin
        $display("malformed record line: %0s", line_buf);
        bad_lines++;
      end
    end
    $fclose(fd);
  endtask

  // a message type of zero stands for no reply at all.
  function automatic dhcp_msg_t make_reply(input test_rec_t r, input logic [7:0] mtype);
    dhcp_msg_t m;
    m = '0;
    m.val                = (mtype != 8'd0);
    m.hdr.op             = r.op;
    m.hdr.htype          = 8'd1;
    m.hdr.hlen           = 8'd6;
    m.hdr.xid            = r.xid;
    m.hdr.yiaddr         = r.yiaddr;
    m.hdr.siaddr         = r.siaddr;
    m.hdr.chaddr         = r.chaddr;
    m.hdr.cookie         = r.cookie;
    m.opt.msg_type       = dhcp_msg_type_e'(mtype);
    m.opt.server_id      = r.sid;
    m.opt.server_id_pres = r.sid_pres;
    m.dst_ip             = 32'hffff_ffff;
    return m;
  endfunction

  task automatic apply_reset();
    @(posedge clk);
    fsm_rst <= 1'b1;
    repeat (3) @(posedge clk);
    fsm_rst <= 1'b0;
  endtask

  task automatic run_test(input test_rec_t r, input string name);
    ipv4_t server;
    server = r.sid_pres ? r.sid : r.siaddr;
    apply_reset();
    ipv4_addr <= r.addr;
    ipv4_req  <= 1'b1;
    @(posedge clk);
    ipv4_req <= 1'b0;
    check_i.expect_tx(name, 2, dhcp_discover, r.addr, '0);
    rx <= make_reply(r, r.mtype);
    @(posedge clk);
    rx.val <= 1'b0;
    if (r.outcome == 2'd0) begin
      // the reply edge already used one cycle of the first wait.
      check_i.expect_tx(name, TIMEOUT_TICKS - 1, dhcp_discover, r.addr, '0);
      repeat (RETRIES - 1) begin
        check_i.expect_tx(name, TIMEOUT_TICKS, dhcp_discover, r.addr, '0);
      end
      check_i.expect_timeout(name, TIMEOUT_TICKS);
    end else begin
      check_i.expect_tx(name, 3, dhcp_request, r.yiaddr, server);
      rx <= make_reply(r, (r.outcome == 2'd1) ? 8'd5 : 8'd6);
      @(posedge clk);
      rx.val <= 1'b0;
      if (r.outcome == 2'd1) begin
        check_i.expect_bound(name, 2, r.yiaddr);
      end else begin
        check_i.expect_tx(name, 3, dhcp_discover, r.addr, '0);
      end
    end
    check_i.close_test(name);
  endtask

  initial begin
    fsm_rst   = 1'b1;
    ipv4_req  = 1'b0;
    ipv4_addr = '0;
    rx        = '0;
    bad_lines = 0;
    loaded    = 1'b0;
    read_records();
    loaded = 1'b1;
    foreach (recs[t]) begin
      run_test(recs[t], names[t]);
    end
    $display("%0d tests passed, %0d tests failed", check_i.pass_cnt, check_i.fail_cnt);
    if (check_i.fail_cnt == 0 && bad_lines == 0 && recs.size() > 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule : dhcp_client_tb

`default_nettype wire

/* dhcp_client.f */
logic/dhcp_pkg.sv
logic/dhcp_rx_filter.sv
logic/dhcp_client_fsm.sv
logic/dhcp_tx_builder.sv
logic/dhcp_client.sv
verif/dhcp_client_checker.sv
verif/dhcp_client_tb.sv

/* verif/dhcp_client_input.txt */
# name addr op xid chaddr cookie msg_type yiaddr sid_pres server_id siaddr outcome
# outcome 0 reply ignored then retries and timeout, 1 offer then ack, 2 offer then nak
offer_ack    00000000 02 3903f326 001b213a4c5d 63825363 02 c0a80164 1 c0a80101 c0a80101 1
req_addr_ack c0a80132 02 3903f326 001b213a4c5d 63825363 02 c0a80132 0 00000000 c0a80102 1
offer_nak    00000000 02 3903f326 001b213a4c5d 63825363 02 0a000005 1 0a000001 00000000 2
req_addr_nak c0a80177 02 3903f326 001b213a4c5d 63825363 02 c0a80178 0 00000000 0a000002 2
bad_xid      00000000 02 3903f327 001b213a4c5d 63825363 02 c0a80164 1 c0a80101 00000000 0
bad_chaddr   00000000 02 3903f326 001b213a4c5e 63825363 02 c0a80164 1 c0a80101 00000000 0
bad_cookie   00000000 02 3903f326 001b213a4c5d 63825362 02 c0a80164 1 c0a80101 00000000 0
op_request   00000000 01 3903f326 001b213a4c5d 63825363 02 c0a80164 1 c0a80101 00000000 0
ack_early    00000000 02 3903f326 001b213a4c5d 63825363 05 c0a80164 1 c0a80101 00000000 0
no_reply     0a0000fe 02 3903f326 001b213a4c5d 63825363 00 00000000 0 00000000 00000000 0
